/* design/gfp8_config.svh */
// GFP8 build parameters for lane, group, address, dimension, result and pipeline sizing
`ifndef GFP8_CONFIG_SVH
`define GFP8_CONFIG_SVH

// ==============================
// Native Vector geometry
// ==============================
// Signed 8-bit lanes in one mantissa line
`define GFP8_LANES 4
// Groups per Native Vector, each a line plus an exponent byte
`define GFP8_GROUPS 4

// ==============================
// Widths
// ==============================
`define GFP8_ADDR_W 9
`define GFP8_DIM_W 8
`define GFP8_MAN_W 32
`define GFP8_EXP_W 8

// ==============================
// Timing and alignment
// ==============================
`define GFP8_DOT_LAT 4
// Largest shift that keeps a mantissa, anything above flushes to zero
`define GFP8_ALIGN_MAX 31

`endif

/* design/gfp8_pkg.sv */
// GFP8 shared types and the block-floating align-and-add function
`default_nettype none
`include "gfp8_config.svh"

package gfp8_pkg;

    // Tile command, sampled on the start edge
    typedef struct packed {
        logic [`GFP8_DIM_W-1:0]  dim_b;
        logic [`GFP8_DIM_W-1:0]  dim_c;
        logic [`GFP8_DIM_W-1:0]  dim_v;
        logic [`GFP8_ADDR_W-1:0] left_base;
        logic [`GFP8_ADDR_W-1:0] right_base;
    } tile_cmd_t;

    // One side's read request, mantissa and exponent share the address
    typedef struct packed {
        logic                    en;
        logic [`GFP8_ADDR_W-1:0] addr;
    } rd_req_t;

    // Data returned one cycle after the request
    typedef struct packed {
        logic [`GFP8_LANES*8-1:0] man;
        logic [`GFP8_EXP_W-1:0]   exp;
    } rd_data_t;

    // One Native Vector, indexed by group
    typedef struct packed {
        logic [`GFP8_GROUPS-1:0][`GFP8_EXP_W-1:0]   exp;
        logic [`GFP8_GROUPS-1:0][`GFP8_LANES*8-1:0] man;
    } nv_buf_t;

    // Block-floating number
    typedef struct packed {
        logic signed [`GFP8_MAN_W-1:0] man;
        logic signed [`GFP8_EXP_W-1:0] exp;
    } gfp_num_t;

    // Align both terms to the larger exponent and add with 32-bit wrap
    function automatic gfp_num_t gfp_align_add(input gfp_num_t a, input gfp_num_t b);
        logic signed [`GFP8_EXP_W-1:0] max_exp;
        logic [`GFP8_EXP_W:0]          diff_a;
        logic [`GFP8_EXP_W:0]          diff_b;
        logic signed [`GFP8_MAN_W-1:0] man_a;
        logic signed [`GFP8_MAN_W-1:0] man_b;
        gfp_num_t                      res;
        if ($signed(a.exp) > $signed(b.exp)) begin
            max_exp = a.exp;
        end else begin
            max_exp = b.exp;
        end
        // Differences are sign extended to 9 bits, never negative
        diff_a = {max_exp[`GFP8_EXP_W-1], max_exp} - {a.exp[`GFP8_EXP_W-1], a.exp};
        diff_b = {max_exp[`GFP8_EXP_W-1], max_exp} - {b.exp[`GFP8_EXP_W-1], b.exp};
        if (diff_a > `GFP8_ALIGN_MAX) begin
            man_a = '0;
        end else begin
            man_a = a.man >>> diff_a;
        end
        if (diff_b > `GFP8_ALIGN_MAX) begin
            man_b = '0;
        end else begin
            man_b = b.man >>> diff_b;
        end
        res.man = man_a + man_b;
        res.exp = max_exp;
        return res;
    endfunction

endpackage

`default_nettype wire

/* design/bcv_sequencer.sv */
// B/C/V loop sequencer with tile start edge, command capture, control FSM and line addresses
`timescale 1ns/10ps
`default_nettype none
`include "gfp8_config.svh"

module bcv_sequencer (
    input  wire logic                      i_clk,
    input  wire logic                      i_reset_n,
    input  wire logic                      i_tile_en,
    input  wire gfp8_pkg::tile_cmd_t       i_tile_cmd,
    input  wire logic                      i_fill_done,
    input  wire logic                      i_dot_valid,
    output logic                           o_fill_start,
    output logic [`GFP8_ADDR_W-1:0]        o_left_line,
    output logic [`GFP8_ADDR_W-1:0]        o_right_line,
    output logic                           o_first_v,
    output logic                           o_last_v,
    output logic                           o_tile_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FILL,
        ST_COMPUTE,
        ST_RETURN,
        ST_DONE
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_next;

    gfp8_pkg::tile_cmd_t      cmd;
    logic                     tile_en_q;
    logic                     tile_start;
    logic                     last_bc;
    logic [`GFP8_DIM_W-1:0]   b_idx;
    logic [`GFP8_DIM_W-1:0]   c_idx;
    logic [`GFP8_DIM_W-1:0]   v_idx;
    logic [2*`GFP8_DIM_W-1:0] left_off;
    logic [2*`GFP8_DIM_W-1:0] right_off;
    logic [`GFP8_ADDR_W-3:0]  left_nv_idx;
    logic [`GFP8_ADDR_W-3:0]  right_nv_idx;

    // ==============================
    // Start edge and loop status
    // ==============================
    // Only a fresh rising edge while idle starts a tile
    assign tile_start = i_tile_en & ~tile_en_q & (state == ST_IDLE);

    assign o_first_v = (v_idx == '0);
    assign o_last_v  = (v_idx == cmd.dim_v - 1'b1);
    // Last output pair of the tile, c runs fastest
    assign last_bc   = (c_idx == cmd.dim_c - 1'b1) && (b_idx == cmd.dim_b - 1'b1);

    // ==============================
    // Control FSM
    // ==============================
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (tile_start) begin
                    state_next = ST_FILL;
                end
            end
            ST_FILL: begin
                if (i_fill_done) begin
                    state_next = ST_COMPUTE;
                end
            end
            // Accumulator takes the dot result in the same cycle as its valid
            ST_COMPUTE: begin
                if (i_dot_valid) begin
                    state_next = o_last_v ? ST_RETURN : ST_FILL;
                end
            end
            ST_RETURN: begin
                state_next = last_bc ? ST_DONE : ST_FILL;
            end
            ST_DONE: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state        <= ST_IDLE;
            tile_en_q    <= 1'b0;
            o_fill_start <= 1'b0;
            cmd          <= '0;
            b_idx        <= '0;
            c_idx        <= '0;
            v_idx        <= '0;
        end else begin
            state     <= state_next;
            tile_en_q <= i_tile_en;
            // One pulse on every entry into the fill state
            o_fill_start <= (state_next == ST_FILL) && (state != ST_FILL);
            if (tile_start) begin
                cmd   <= i_tile_cmd;
                b_idx <= '0;
                c_idx <= '0;
                v_idx <= '0;
            end
            // Next Native Vector of the same output pair
            if (state == ST_COMPUTE && i_dot_valid && !o_last_v) begin
                v_idx <= v_idx + 1'b1;
            end
            // Step to the next (b,c) pair
            if (state == ST_RETURN && !last_bc) begin
                v_idx <= '0;
                if (c_idx == cmd.dim_c - 1'b1) begin
                    c_idx <= '0;
                    b_idx <= b_idx + 1'b1;
                end else begin
                    c_idx <= c_idx + 1'b1;
                end
            end
        end
    end

    assign o_tile_done = (state == ST_DONE);

    // ==============================
    // Line addresses
    // ==============================
    // Native Vector index is base/4 + row*V + v, kept modulo the line space
    assign left_off     = b_idx * cmd.dim_v + {{`GFP8_DIM_W{1'b0}}, v_idx};
    assign right_off    = c_idx * cmd.dim_v + {{`GFP8_DIM_W{1'b0}}, v_idx};
    assign left_nv_idx  = cmd.left_base[`GFP8_ADDR_W-1:2] + left_off[`GFP8_ADDR_W-3:0];
    assign right_nv_idx = cmd.right_base[`GFP8_ADDR_W-1:2] + right_off[`GFP8_ADDR_W-3:0];

    // Group 0 line, nv_fill adds the group number
    assign o_left_line  = {left_nv_idx, 2'b00};
    assign o_right_line = {right_nv_idx, 2'b00};

endmodule

`default_nettype wire

/* design/nv_fill.sv */
// Five-cycle group fill of the left and right Native Vector buffers
`timescale 1ns/10ps
`default_nettype none
`include "gfp8_config.svh"

module nv_fill (
    input  wire logic                   i_clk,
    input  wire logic                   i_reset_n,
    input  wire logic                   i_fill_start,
    input  wire logic [`GFP8_ADDR_W-1:0] i_left_line,
    input  wire logic [`GFP8_ADDR_W-1:0] i_right_line,
    output gfp8_pkg::rd_req_t           o_left_rd,
    output gfp8_pkg::rd_req_t           o_right_rd,
    input  wire gfp8_pkg::rd_data_t     i_left_rd,
    input  wire gfp8_pkg::rd_data_t     i_right_rd,
    output gfp8_pkg::nv_buf_t           o_left_nv,
    output gfp8_pkg::nv_buf_t           o_right_nv,
    output logic                        o_fill_done
);

    logic       busy;
    logic [2:0] grp_cnt;
    logic [1:0] issue_grp;
    logic       issue_en;
    logic [1:0] cap_grp;

    // Group 0 goes out in the start cycle, groups 1 to 3 follow from the counter
    assign issue_en  = i_fill_start | (busy & ~grp_cnt[2]);
    assign issue_grp = i_fill_start ? 2'd0 : grp_cnt[1:0];
    // Returned data belongs to the group issued one cycle earlier
    assign cap_grp   = grp_cnt[1:0] - 2'd1;

    assign o_left_rd.en    = issue_en;
    assign o_left_rd.addr  = i_left_line + {{(`GFP8_ADDR_W-2){1'b0}}, issue_grp};
    assign o_right_rd.en   = issue_en;
    assign o_right_rd.addr = i_right_line + {{(`GFP8_ADDR_W-2){1'b0}}, issue_grp};

    // ==============================
    // Group counter
    // ==============================
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            busy        <= 1'b0;
            grp_cnt     <= '0;
            o_fill_done <= 1'b0;
        end else begin
            o_fill_done <= 1'b0;
            if (i_fill_start) begin
                busy    <= 1'b1;
                grp_cnt <= 3'd1;
            end else if (busy) begin
                grp_cnt <= grp_cnt + 3'd1;
                // Group 3 lands now, both buffers complete next cycle
                if (grp_cnt == 3'd4) begin
                    busy        <= 1'b0;
                    o_fill_done <= 1'b1;
                end
            end
        end
    end

    // Buffers hold until the next fill writes over them
    always_ff @(posedge i_clk) begin
        if (busy) begin
            o_left_nv.man[cap_grp]  <= i_left_rd.man;
            o_left_nv.exp[cap_grp]  <= i_left_rd.exp;
            o_right_nv.man[cap_grp] <= i_right_rd.man;
            o_right_nv.exp[cap_grp] <= i_right_rd.exp;
        end
    end

endmodule

`default_nettype wire

/* design/nv_dot.sv */
// Four-stage block-floating dot product of two Native Vectors
`timescale 1ns/10ps
`default_nettype none
`include "gfp8_config.svh"

module nv_dot (
    input  wire logic               i_clk,
    input  wire logic               i_reset_n,
    input  wire logic               i_valid,
    input  wire gfp8_pkg::nv_buf_t  i_left_nv,
    input  wire gfp8_pkg::nv_buf_t  i_right_nv,
    output gfp8_pkg::gfp_num_t      o_dot,
    output logic                    o_valid
);

    gfp8_pkg::gfp_num_t [`GFP8_GROUPS-1:0] grp_dot;
    gfp8_pkg::gfp_num_t [`GFP8_GROUPS-1:0] s1_grp;
    gfp8_pkg::gfp_num_t [1:0]              s2_pair;
    gfp8_pkg::gfp_num_t                    s3_sum;
    logic [`GFP8_DOT_LAT-1:0]              vld_pipe;

    // ==============================
    // Lane products per group
    // ==============================
    always_comb begin : lane_mac
        logic signed [`GFP8_MAN_W-1:0] lane_sum;
        logic signed [15:0]            prod;
        logic signed [7:0]             l_lane;
        logic signed [7:0]             r_lane;
        for (int g = 0; g < `GFP8_GROUPS; g++) begin
            lane_sum = '0;
            for (int k = 0; k < `GFP8_LANES; k++) begin
                l_lane   = i_left_nv.man[g][8*k +: 8];
                r_lane   = i_right_nv.man[g][8*k +: 8];
                prod     = l_lane * r_lane;
                lane_sum = lane_sum + prod;
            end
            grp_dot[g].man = lane_sum;
            // Group exponent wraps at 8 bits
            grp_dot[g].exp = i_left_nv.exp[g] + i_right_nv.exp[g];
        end
    end

    // ==============================
    // Data pipeline
    // ==============================
    always_ff @(posedge i_clk) begin
        // Stage 1 holds the four group results
        s1_grp     <= grp_dot;
        // Stage 2 merges neighbouring groups
        s2_pair[0] <= gfp8_pkg::gfp_align_add(s1_grp[0], s1_grp[1]);
        s2_pair[1] <= gfp8_pkg::gfp_align_add(s1_grp[2], s1_grp[3]);
        // Stage 3 merges the pairs
        s3_sum     <= gfp8_pkg::gfp_align_add(s2_pair[0], s2_pair[1]);
        // Stage 4 output register
        o_dot      <= s3_sum;
    end

    // Valid travels alongside the data
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[`GFP8_DOT_LAT-2:0], i_valid};
        end
    end

    assign o_valid = vld_pipe[`GFP8_DOT_LAT-1];

endmodule

`default_nettype wire

/* design/v_accum.sv */
// V-loop aligning accumulator with registered result output
`timescale 1ns/10ps
`default_nettype none

module v_accum (
    input  wire logic               i_clk,
    input  wire logic               i_reset_n,
    input  wire logic               i_dot_valid,
    input  wire gfp8_pkg::gfp_num_t i_dot,
    input  wire logic               i_first_v,
    input  wire logic               i_last_v,
    output gfp8_pkg::gfp_num_t      o_result,
    output logic                    o_result_valid
);

    gfp8_pkg::gfp_num_t acc_sum;
    gfp8_pkg::gfp_num_t acc_next;

    // ==============================
    // Next running sum
    // ==============================
    always_comb begin
        if (i_first_v) begin
            // First Native Vector of an output pair loads directly
            acc_next = i_dot;
        end else begin
            acc_next = gfp8_pkg::gfp_align_add(acc_sum, i_dot);
        end
    end

    // Sum and result words
    always_ff @(posedge i_clk) begin
        if (i_dot_valid) begin
            acc_sum <= acc_next;
            if (i_last_v) begin
                o_result <= acc_next;
            end
        end
    end

    // Result valid is a single-cycle pulse after the last dot
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= i_dot_valid & i_last_v;
        end
    end

endmodule

`default_nettype wire

/* design/gfp8_bcv_top.sv */
// GFP8 matrix-multiply loop sequencer top with sequencer, fill, dot and accumulator
`timescale 1ns/10ps
`default_nettype none
`include "gfp8_config.svh"

module gfp8_bcv_top (
    input  wire logic                i_clk,
    input  wire logic                i_reset_n,
    input  wire logic                i_tile_en,
    input  wire gfp8_pkg::tile_cmd_t i_tile_cmd,
    output logic                     o_tile_done,
    output gfp8_pkg::rd_req_t        o_left_rd,
    output gfp8_pkg::rd_req_t        o_right_rd,
    input  wire gfp8_pkg::rd_data_t  i_left_rd,
    input  wire gfp8_pkg::rd_data_t  i_right_rd,
    output gfp8_pkg::gfp_num_t       o_result,
    output logic                     o_result_valid
);

    logic                    fill_start;
    logic                    fill_done;
    logic [`GFP8_ADDR_W-1:0] left_line;
    logic [`GFP8_ADDR_W-1:0] right_line;
    logic                    first_v;
    logic                    last_v;
    gfp8_pkg::nv_buf_t       left_nv;
    gfp8_pkg::nv_buf_t       right_nv;
    gfp8_pkg::gfp_num_t      dot;
    logic                    dot_valid;

    // Loop control and line addresses
    bcv_sequencer u_bcv_sequencer (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_tile_en    (i_tile_en),
        .i_tile_cmd   (i_tile_cmd),
        .i_fill_done  (fill_done),
        .i_dot_valid  (dot_valid),
        .o_fill_start (fill_start),
        .o_left_line  (left_line),
        .o_right_line (right_line),
        .o_first_v    (first_v),
        .o_last_v     (last_v),
        .o_tile_done  (o_tile_done)
    );

    // Memory reads into the Native Vector buffers
    nv_fill u_nv_fill (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_fill_start (fill_start),
        .i_left_line  (left_line),
        .i_right_line (right_line),
        .o_left_rd    (o_left_rd),
        .o_right_rd   (o_right_rd),
        .i_left_rd    (i_left_rd),
        .i_right_rd   (i_right_rd),
        .o_left_nv    (left_nv),
        .o_right_nv   (right_nv),
        .o_fill_done  (fill_done)
    );

    // Fill done doubles as the dot input valid
    nv_dot u_nv_dot (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_valid    (fill_done),
        .i_left_nv  (left_nv),
        .i_right_nv (right_nv),
        .o_dot      (dot),
        .o_valid    (dot_valid)
    );

    v_accum u_v_accum (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_dot_valid    (dot_valid),
        .i_dot          (dot),
        .i_first_v      (first_v),
        .i_last_v       (last_v),
        .o_result       (o_result),
        .o_result_valid (o_result_valid)
    );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
// Testbench clock and reset generator
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_reset_n
);

    // 4 ns clock
    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Reset released on a falling edge, away from the DUT's sampling edge
    initial begin
        o_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_bcv.sv */
// Testbench for the GFP8 loop sequencer with memory model, data reader, monitor and checks
`timescale 1ns/10ps
`default_nettype none
`include "gfp8_config.svh"

module tb_bcv;

    localparam int MEM_LINES = 1 << `GFP8_ADDR_W;
    localparam int MAX_TILES = 8;
    localparam int MAX_RES   = 64;
    localparam int WAIT_MAX  = 5000;

    logic                clk;
    logic                reset_n;
    logic                tile_en;
    gfp8_pkg::tile_cmd_t tile_cmd;
    logic                tile_done;
    gfp8_pkg::rd_req_t   left_req;
    gfp8_pkg::rd_req_t   right_req;
    gfp8_pkg::rd_data_t  left_rd = '0;
    gfp8_pkg::rd_data_t  right_rd = '0;
    gfp8_pkg::gfp_num_t  result;
    logic                result_valid;

    // Memory image with one line and one exponent per side
    logic [`GFP8_LANES*8-1:0] left_man [MEM_LINES];
    logic [`GFP8_EXP_W-1:0]   left_exp [MEM_LINES];
    logic [`GFP8_LANES*8-1:0] right_man [MEM_LINES];
    logic [`GFP8_EXP_W-1:0]   right_exp [MEM_LINES];

    // Tile commands and expected results from the data file
    gfp8_pkg::tile_cmd_t tile_list [MAX_TILES];
    string               tile_name [MAX_TILES];
    int                  tile_hold [MAX_TILES];
    int                  exp_first [MAX_TILES];
    int                  exp_count [MAX_TILES];
    logic [31:0]         exp_man [MAX_RES];
    logic [7:0]          exp_exp [MAX_RES];
    int                  n_tiles = 0;
    int                  n_exp = 0;

    // Monitor records
    logic [31:0] got_man [MAX_RES];
    logic [7:0]  got_exp [MAX_RES];
    int          cyc = 0;
    int          res_total = 0;
    int          done_total = 0;
    int          rd_total = 0;
    int          last_valid_cyc = 0;
    int          done_cyc = 0;

    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] rng = 32'd10;

    tb_clock u_tb_clock (
        .o_clk     (clk),
        .o_reset_n (reset_n)
    );

    gfp8_bcv_top u_gfp8_bcv_top (
        .i_clk          (clk),
        .i_reset_n      (reset_n),
        .i_tile_en      (tile_en),
        .i_tile_cmd     (tile_cmd),
        .o_tile_done    (tile_done),
        .o_left_rd      (left_req),
        .o_right_rd     (right_req),
        .i_left_rd      (left_rd),
        .i_right_rd     (right_rd),
        .o_result       (result),
        .o_result_valid (result_valid)
    );

    // ==============================
    // Memory model and monitor
    // ==============================
    // Data for a request shows up one cycle later
    always @(posedge clk) begin
        if (left_req.en) begin
            left_rd.man <= left_man[left_req.addr];
            left_rd.exp <= left_exp[left_req.addr];
        end
        if (right_req.en) begin
            right_rd.man <= right_man[right_req.addr];
            right_rd.exp <= right_exp[right_req.addr];
        end
    end

    // Results, done pulses and read cycles with their cycle stamps
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (reset_n) begin
            if (result_valid && res_total < MAX_RES) begin
                got_man[res_total] <= result.man;
                got_exp[res_total] <= result.exp;
                res_total          <= res_total + 1;
                last_valid_cyc     <= cyc;
            end
            if (tile_done) begin
                done_total <= done_total + 1;
                done_cyc   <= cyc;
            end
            if (left_req.en || right_req.en) begin
                rd_total <= rd_total + 1;
            end
        end
    end

    // ==============================
    // Helpers
    // ==============================
    // Xorshift step on the shared state
    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // A wait that ran out counts as an error
    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("Test %s: %s", name, (errors == err_before) ? "pass" : "FAIL");
    endtask

    // Fill all lines with an address pattern before reading the data file
    task automatic read_data_file();
        int          fd;
        int          code;
        string       line;
        string       nm;
        int          a;
        int          b;
        int          c;
        int          v;
        int          lb;
        int          rb;
        int          h;
        logic [31:0] lm;
        logic [31:0] rm;
        logic [7:0]  le;
        logic [7:0]  re;
        logic [8:0]  addr;
        for (int i = 0; i < MEM_LINES; i++) begin
            addr         = 9'(i);
            left_man[i]  = {7'd0, addr, 7'd0, addr};
            left_exp[i]  = addr[8:1];
            right_man[i] = ~{7'd0, addr, 7'd0, addr};
            right_exp[i] = addr[7:0];
        end
        fd = $fopen("sim/bcv_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test data file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // Lines starting with any other character are comments
                if (code > 1) begin
                    if (line.getc(0) == "M") begin
                        code = $sscanf(line, "M %h %h %h %h %h", a, lm, le, rm, re);
                        left_man[a]  = lm;
                        left_exp[a]  = le;
                        right_man[a] = rm;
                        right_exp[a] = re;
                    end else if (line.getc(0) == "T") begin
                        code = $sscanf(line, "T %s %d %d %d %h %h %d", nm, b, c, v, lb, rb, h);
                        tile_list[n_tiles].dim_b      = 8'(b);
                        tile_list[n_tiles].dim_c      = 8'(c);
                        tile_list[n_tiles].dim_v      = 8'(v);
                        tile_list[n_tiles].left_base  = 9'(lb);
                        tile_list[n_tiles].right_base = 9'(rb);
                        tile_name[n_tiles] = nm;
                        tile_hold[n_tiles] = h;
                        exp_first[n_tiles] = n_exp;
                        exp_count[n_tiles] = 0;
                        n_tiles++;
                    end else if (line.getc(0) == "R") begin
                        // Result lines belong to the tile above them
                        code = $sscanf(line, "R %h %h", lm, le);
                        exp_man[n_exp] = lm;
                        exp_exp[n_exp] = le;
                        exp_count[n_tiles-1]++;
                        n_exp++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ==============================
    // One tile, its results and the quiet window after done
    // ==============================
    task automatic run_tile(input int t);
        int gap;
        int guard;
        int res0;
        int done0;
        int res1;
        int rd1;
        int n;
        int err0;
        err0  = errors;
        gap   = int'(next_random() % 8) + 2;
        repeat (gap) @(posedge clk);
        res0  = res_total;
        done0 = done_total;
        // Rising edge of the enable starts the tile
        tile_cmd <= tile_list[t];
        tile_en  <= 1'b1;
        @(posedge clk);
        if (tile_hold[t] == 0) begin
            tile_en <= 1'b0;
        end
        guard = 0;
        while (done_total == done0) begin
            if (guard >= WAIT_MAX) begin
                report_timeout({"o_tile_done in ", tile_name[t]});
                break;
            end
            @(posedge clk);
            guard++;
        end
        // Results in (b,c) order with c fastest
        n = res_total - res0;
        check_value("result count", 64'(n), 64'(exp_count[t]));
        for (int i = 0; i < n && i < exp_count[t]; i++) begin
            check_value("o_result.man", 64'(got_man[res0+i]), 64'(exp_man[exp_first[t]+i]));
            check_value("o_result.exp", 64'(got_exp[res0+i]), 64'(exp_exp[exp_first[t]+i]));
        end
        check_value("o_tile_done delay", 64'(done_cyc - last_valid_cyc), 64'd1);
        // Nothing may move while idle even with i_tile_en still high
        res1 = res_total;
        rd1  = rd_total;
        repeat (12) @(posedge clk);
        check_value("o_result_valid after done", 64'(res_total - res1), 64'd0);
        check_value("o_tile_done pulses", 64'(done_total - done0), 64'd1);
        check_value("read enables while idle", 64'(rd_total - rd1), 64'd0);
        tile_en <= 1'b0;
        report_test(tile_name[t], err0);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin : main_seq
        int guard;
        int err0;
        tile_en  = 1'b0;
        tile_cmd = '0;
        read_data_file();
        guard = 0;
        while (!reset_n) begin
            if (guard >= 100) begin
                report_timeout("reset release");
                break;
            end
            @(posedge clk);
            guard++;
        end
        @(posedge clk);
        // Every enable, valid and done output idles low
        err0 = errors;
        check_value("o_left_rd.en", 64'(left_req.en), 64'd0);
        check_value("o_right_rd.en", 64'(right_req.en), 64'd0);
        check_value("o_result_valid", 64'(result_valid), 64'd0);
        check_value("o_tile_done", 64'(tile_done), 64'd0);
        report_test("reset", err0);
        for (int t = 0; t < n_tiles; t++) begin
            run_tile(t);
        end
        $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && n_tiles > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/bcv_testdata.txt */
# M addr left_man left_exp right_man right_exp (hex), lanes low byte first
# T name B C V left_base right_base(hex) hold_en, then R man exp (hex) per (b,c)
M 000 04030201 01 01010101 00
M 001 00000002 00 00000005 00
M 002 000000ff 02 00000004 00
M 003 00000303 00 00000101 01
M 010 00000004 20 00000002 08
M 011 00000000 00 00000000 00
M 012 00000000 00 00000000 00
M 013 00000000 00 00000000 00
M 014 00000003 01 00000003 01
M 015 00000000 00 00000000 00
M 016 00000000 00 00000000 00
M 017 00000000 00 00000000 00
M 018 00000040 10 00000020 0f
M 019 00000000 00 00000000 00
M 01a 00000000 00 00000000 00
M 01b 00000000 00 00000000 00
M 040 00000000 00 00000001 00
M 041 00000000 00 00000000 00
M 042 00000000 00 00000000 00
M 043 00000000 00 00000000 00
M 044 00000102 01 00000100 02
M 045 00000000 00 00000000 00
M 046 00000000 00 00000000 00
M 047 00000000 00 00000000 00
M 048 050000fd 00 01010101 03
M 049 00000000 00 00000000 00
M 04a 00000000 00 00000000 00
M 04b 00000000 00 00000000 00
T single_1x1x1 1 1 1 000 000 0
R 00000006 02
T v3_flush_hold 1 1 3 010 010 1
R 0000000c 28
T tile_2x3_offset 2 3 1 044 040 0
R 00000002 01
R 00000001 03
R 00000003 04
R fffffffd 00
R 00000000 02
R 00000002 03

/* list.f */
+incdir+design
design/gfp8_pkg.sv
design/bcv_sequencer.sv
design/nv_fill.sv
design/nv_dot.sv
design/v_accum.sv
design/gfp8_bcv_top.sv
sim/tb_clock.sv
sim/tb_bcv.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bcv
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
